//--- rename_pkg.sv
package rename_pkg;

    // Dispatch group shape
    parameter int issue_width    = 3;            // Slots renamed per cycle

    // Architectural register file
    parameter int arch_reg_count = 32;           // x0 to x31
    parameter int arch_reg_bits  = $clog2(arch_reg_count); // Index width

    // Reorder buffer tags
    parameter int rob_tag_bits   = 5;            // 32 in-flight tags

    // Register index as it comes from decode
    typedef logic [arch_reg_bits-1:0] arch_reg_t;

    // Tag handed out by the reorder buffer allocator
    typedef logic [rob_tag_bits-1:0]  rob_tag_t;

endpackage

//--- rename_packet_pkg.sv
package rename_packet_pkg;

    // One dispatched instruction, register indices already decoded
    typedef struct packed {
        logic                valid;              // Slot holds a legal instruction
        rename_pkg::arch_reg_t src1;             // First source register
        rename_pkg::arch_reg_t src2;             // Second source register
        logic                dest_valid;         // Instruction writes a register
        rename_pkg::arch_reg_t dest;             // Destination register
        rename_pkg::rob_tag_t  dest_tag;         // Newly allocated ROB tag
    } dispatch_slot_t;

    // One completion broadcast from the CDB
    typedef struct packed {
        logic                 valid;             // Broadcast present this cycle
        rename_pkg::rob_tag_t tag;               // Tag whose result is done
    } cdb_bcast_t;

    // Lookup outcome for one source operand
    typedef struct packed {
        logic                 mapped;            // Value comes from an in-flight tag
        rename_pkg::rob_tag_t tag;               // Producer tag, zero when unmapped
        logic                 ready;             // Producer already broadcast
    } src_map_t;

    // Registered output for one dispatch slot
    typedef struct packed {
        logic     valid;                         // Slot was valid one cycle ago
        src_map_t src1;
        src_map_t src2;
    } rename_result_t;

    // Destination update into the map table
    typedef struct packed {
        logic                  valid;            // Write enable
        rename_pkg::arch_reg_t dest;             // Register being renamed
        rename_pkg::rob_tag_t  tag;              // New producer tag
    } map_write_t;

endpackage

//--- map_table_store.sv
`timescale 1ns/1ps

module map_table_store #(
    parameter int cdb_ports = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic squash,
    input  rename_packet_pkg::map_write_t [rename_pkg::issue_width-1:0] writes,
    input  rename_packet_pkg::cdb_bcast_t [cdb_ports-1:0]               cdb,
    output rename_pkg::rob_tag_t [rename_pkg::arch_reg_count-1:0]      tag_table,
    output logic [rename_pkg::arch_reg_count-1:0]                      mapped_bits,
    output logic [rename_pkg::arch_reg_count-1:0]                      ready_bits
);

    rename_pkg::rob_tag_t [rename_pkg::arch_reg_count-1:0] tag_q;    // Producer tag per register
    rename_pkg::rob_tag_t [rename_pkg::arch_reg_count-1:0] tag_d;
    logic [rename_pkg::arch_reg_count-1:0] mapped_q;                // Register waits on a tag
    logic [rename_pkg::arch_reg_count-1:0] mapped_d;
    logic [rename_pkg::arch_reg_count-1:0] ready_q;                 // Tag already on the CDB
    logic [rename_pkg::arch_reg_count-1:0] ready_d;

    // Next state of the table
    always_comb begin
        tag_d    = tag_q;
        mapped_d = mapped_q;
        ready_d  = ready_q;

        // Wake-up first so that a same-edge write overrides it
        for (int r = 1; r < rename_pkg::arch_reg_count; r++) begin
            for (int p = 0; p < cdb_ports; p++) begin
                if (cdb[p].valid && mapped_q[r] && tag_q[r] == cdb[p].tag) begin
                    ready_d[r] = 1'b1;                      // Producer finished
                end
            end
        end

        // Slot order so the youngest writer of a register wins
        for (int s = 0; s < rename_pkg::issue_width; s++) begin
            if (writes[s].valid && writes[s].dest != '0) begin
                tag_d[writes[s].dest]    = writes[s].tag;   // New producer
                mapped_d[writes[s].dest] = 1'b1;
                ready_d[writes[s].dest]  = 1'b0;            // Not produced yet
            end
        end

        // x0 stays architectural
        tag_d[0]    = '0;
        mapped_d[0] = 1'b0;
        ready_d[0]  = 1'b0;
    end

    // Squash drops every in-flight mapping
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            mapped_q <= '0;                                 // All reads from the ARF
            ready_q  <= '0;
        end else begin
            mapped_q <= mapped_d;
            ready_q  <= ready_d;
        end
    end

    // Producer tag storage
    always_ff @(posedge clock) begin
        tag_q <= tag_d;
    end

    assign tag_table   = tag_q;
    assign mapped_bits = mapped_q;
    assign ready_bits  = ready_q;

    // Decode must never rename x0
    for (genvar s = 0; s < rename_pkg::issue_width; s++) begin : g_write_chk
        a_no_x0_write: assert property (
            @(posedge clock) disable iff (reset)
            writes[s].valid |-> writes[s].dest != '0
        ) else $error("map_table_store: slot %0d writes x0", s);
    end

    // Execution units complete distinct ROB entries
    for (genvar p = 0; p < cdb_ports; p++) begin : g_cdb_outer
        for (genvar q = p + 1; q < cdb_ports; q++) begin : g_cdb_inner
            a_cdb_distinct: assert property (
                @(posedge clock) disable iff (reset)
                (cdb[p].valid && cdb[q].valid) |-> cdb[p].tag != cdb[q].tag
            ) else $error("map_table_store: CDB %0d and %0d share a tag", p, q);
        end
    end

endmodule

//--- source_lookup.sv
`timescale 1ns/1ps

module source_lookup #(
    parameter int cdb_ports = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic squash,
    input  rename_packet_pkg::dispatch_slot_t [rename_pkg::issue_width-1:0] dispatch,
    input  rename_packet_pkg::cdb_bcast_t [cdb_ports-1:0]                   cdb,
    input  rename_pkg::rob_tag_t [rename_pkg::arch_reg_count-1:0]          tag_table,
    input  logic [rename_pkg::arch_reg_count-1:0]                          mapped_bits,
    input  logic [rename_pkg::arch_reg_count-1:0]                          ready_bits,
    output rename_packet_pkg::rename_result_t [rename_pkg::issue_width-1:0] result
);

    rename_packet_pkg::rename_result_t [rename_pkg::issue_width-1:0] result_d; // Next group
    rename_packet_pkg::rename_result_t [rename_pkg::issue_width-1:0] result_q; // Output register

    // Same-cycle completion of a stored tag
    function automatic logic cdb_hit(rename_pkg::rob_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < cdb_ports; p++) begin
            if (cdb[p].valid && cdb[p].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Resolve one source of a slot against the group and the table
    function automatic rename_packet_pkg::src_map_t lookup_src(
        rename_pkg::arch_reg_t src,
        int                    slot
    );
        rename_packet_pkg::src_map_t m;
        logic                        fwd;
        m   = '0;                                       // Unmapped, tag 0, not ready
        fwd = 1'b0;
        if (src != '0) begin
            // Older slots in this group where the youngest one wins
            for (int j = 0; j < rename_pkg::issue_width; j++) begin
                if (j < slot && dispatch[j].valid && dispatch[j].dest_valid
                        && dispatch[j].dest == src) begin
                    m.mapped = 1'b1;
                    m.tag    = dispatch[j].dest_tag;
                    m.ready  = 1'b0;                    // Producer not even issued
                    fwd      = 1'b1;
                end
            end
            // Fall back to the committed table state
            if (!fwd && mapped_bits[src]) begin
                m.mapped = 1'b1;
                m.tag    = tag_table[src];
                m.ready  = ready_bits[src] || cdb_hit(tag_table[src]); // CDB bypass
            end
        end
        return m;
    endfunction

    // Per-slot lookup
    always_comb begin
        for (int i = 0; i < rename_pkg::issue_width; i++) begin
            result_d[i] = '0;                           // Invalid slot reads all zero
            if (dispatch[i].valid) begin
                result_d[i].valid = 1'b1;
                result_d[i].src1  = lookup_src(dispatch[i].src1, i);
                result_d[i].src2  = lookup_src(dispatch[i].src2, i);
            end
        end
    end

    // One cycle of latency and squash kills the group in flight
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            result_q <= '0;
        end else begin
            result_q <= result_d;
        end
    end

    assign result = result_q;

    // Ready only ever accompanies a real mapping
    for (genvar i = 0; i < rename_pkg::issue_width; i++) begin : g_result_chk
        a_src1_ready_mapped: assert property (
            @(posedge clock) disable iff (reset)
            result[i].src1.ready |-> result[i].src1.mapped
        ) else $error("source_lookup: slot %0d src1 ready but unmapped", i);

        a_src2_ready_mapped: assert property (
            @(posedge clock) disable iff (reset)
            result[i].src2.ready |-> result[i].src2.mapped
        ) else $error("source_lookup: slot %0d src2 ready but unmapped", i);
    end

endmodule

//--- rename_top.sv
`timescale 1ns/1ps

module rename_top #(
    parameter int cdb_ports = 3                         // Completion buses
) (
    input  logic clock,
    input  logic reset,
    input  logic squash,
    input  rename_packet_pkg::dispatch_slot_t [rename_pkg::issue_width-1:0] dispatch,
    input  rename_packet_pkg::cdb_bcast_t [cdb_ports-1:0]                   cdb,
    output rename_packet_pkg::rename_result_t [rename_pkg::issue_width-1:0] result
);

    rename_packet_pkg::map_write_t [rename_pkg::issue_width-1:0] writes; // Dest updates
    rename_pkg::rob_tag_t [rename_pkg::arch_reg_count-1:0]       tag_table;
    logic [rename_pkg::arch_reg_count-1:0]                       mapped_bits;
    logic [rename_pkg::arch_reg_count-1:0]                       ready_bits;

    // Only valid slots with a destination rename anything
    always_comb begin
        for (int i = 0; i < rename_pkg::issue_width; i++) begin
            writes[i].valid = dispatch[i].valid && dispatch[i].dest_valid;
            writes[i].dest  = dispatch[i].dest;
            writes[i].tag   = dispatch[i].dest_tag;
        end
    end

    map_table_store #(
        .cdb_ports (cdb_ports)
    ) i_store (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .writes      (writes),
        .cdb         (cdb),
        .tag_table   (tag_table),
        .mapped_bits (mapped_bits),
        .ready_bits  (ready_bits)
    );

    source_lookup #(
        .cdb_ports (cdb_ports)
    ) i_lookup (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .tag_table   (tag_table),
        .mapped_bits (mapped_bits),
        .ready_bits  (ready_bits),
        .result      (result)
    );

endmodule

//--- tb_rename_model.svh
`ifndef TB_RENAME_MODEL_SVH
`define TB_RENAME_MODEL_SVH

// Reference copy of the rename state, one entry per architectural register
rename_pkg::rob_tag_t model_tag    [rename_pkg::arch_reg_count];
logic                 model_mapped [rename_pkg::arch_reg_count];
logic                 model_ready  [rename_pkg::arch_reg_count];

int unsigned lcg_state = 32'd24925;                  // Fixed seed

// Next LCG value folded into 0 .. n-1
function automatic int unsigned lcg_range(int unsigned n);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % n;                    // High bits are the better ones
endfunction

// Any valid completion bus carrying this tag
function automatic logic broadcast_done(cdb_group_t c, rename_pkg::rob_tag_t tag);
    logic done;
    done = 1'b0;
    for (int p = 0; p < cdb_ports; p++) begin
        done = done | (c[p].valid && c[p].tag == tag);
    end
    return done;
endfunction

// Expected lookup of one source, priority as the rename rules give it
function automatic rename_packet_pkg::src_map_t model_source(
    rename_pkg::arch_reg_t src,
    int                    slot,
    dispatch_group_t       d,
    cdb_group_t            c
);
    rename_packet_pkg::src_map_t s;
    logic                        found;
    s     = '0;                                      // Unmapped reads tag 0, not ready
    found = 1'b0;
    if (src != 5'd0) begin
        // Walk back from the nearest older slot
        for (int j = slot - 1; j >= 0; j--) begin
            if (!found && d[j].valid && d[j].dest_valid && d[j].dest == src) begin
                s.mapped = 1'b1;
                s.tag    = d[j].dest_tag;
                found    = 1'b1;
            end
        end
        if (!found && model_mapped[src]) begin
            s.mapped = 1'b1;
            s.tag    = model_tag[src];
            s.ready  = model_ready[src] || broadcast_done(c, model_tag[src]);
        end
    end
    return s;
endfunction

// Whole group as it should come out one cycle later
function automatic result_group_t model_group(dispatch_group_t d, cdb_group_t c);
    result_group_t g;
    g = '0;
    for (int i = 0; i < rename_pkg::issue_width; i++) begin
        if (d[i].valid) begin
            g[i].valid = 1'b1;
            g[i].src1  = model_source(d[i].src1, i, d, c);
            g[i].src2  = model_source(d[i].src2, i, d, c);
        end
    end
    return g;
endfunction

// Table update at the clock edge
function automatic void model_commit(dispatch_group_t d, cdb_group_t c, logic flush);
    if (flush) begin
        for (int r = 0; r < rename_pkg::arch_reg_count; r++) begin
            model_tag[r]    = '0;
            model_mapped[r] = 1'b0;
            model_ready[r]  = 1'b0;
        end
    end else begin
        for (int r = 1; r < rename_pkg::arch_reg_count; r++) begin
            if (model_mapped[r] && broadcast_done(c, model_tag[r])) begin
                model_ready[r] = 1'b1;               // Producer has completed
            end
        end
        for (int s = 0; s < rename_pkg::issue_width; s++) begin
            if (d[s].valid && d[s].dest_valid && d[s].dest != 5'd0) begin
                model_tag[d[s].dest]    = d[s].dest_tag;
                model_mapped[d[s].dest] = 1'b1;
                model_ready[d[s].dest]  = 1'b0;      // Beats a same-edge wake-up
            end
        end
    end
endfunction

`endif

//--- tb_rename.sv
`timescale 1ns/1ps

module tb_rename;

    localparam int cdb_ports       = 3;
    localparam int clock_period    = 100;              // ns
    localparam int reset_cycles    = 5;
    localparam int directed_cycles = 24;               // Budget per directed test
    localparam int random_cycles   = 300;
    localparam int watchdog_cycles = reset_cycles + 4 * directed_cycles + random_cycles + 100;

    typedef rename_packet_pkg::dispatch_slot_t [rename_pkg::issue_width-1:0] dispatch_group_t;
    typedef rename_packet_pkg::cdb_bcast_t [cdb_ports-1:0]                   cdb_group_t;
    typedef rename_packet_pkg::rename_result_t [rename_pkg::issue_width-1:0] result_group_t;

    logic            clock;
    logic            reset;
    logic            squash;
    dispatch_group_t dispatch;
    cdb_group_t      cdb;
    result_group_t   result;

    result_group_t   expected_q;                       // Model view of what is on result
    logic            flush_q;                          // Last edge saw reset or squash
    logic            check_en = 1'b0;                  // Output defined after first edge
    logic [rename_pkg::issue_width-1:0] result_valids;

    string test_name    = "reset";
    int    test_errors  = 0;
    int    error_count  = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    check_count  = 0;

    `include "tb_rename_model.svh"

    rename_top #(
        .cdb_ports (cdb_ports)
    ) i_dut (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .cdb      (cdb),
        .result   (result)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Model runs alongside the DUT, expectation lines up with the DUT register
    always @(posedge clock) begin
        if (reset || squash) begin
            expected_q <= '0;
        end else begin
            expected_q <= model_group(dispatch, cdb);
        end
        flush_q  <= reset || squash;
        check_en <= 1'b1;
        model_commit(dispatch, cdb, reset || squash);
    end

    always_comb begin
        for (int i = 0; i < rename_pkg::issue_width; i++) begin
            result_valids[i] = result[i].valid;
        end
    end

    always @(negedge clock) begin
        if (check_en) begin
            check_count++;                             // One group compared per cycle
        end
    end

    function automatic void report_mismatch(string what, logic [63:0] expected,
                                            logic [63:0] actual);
        $display("Fail %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
        test_errors++;
        error_count++;
    endfunction

    function automatic void report_problem(string what);
        $display("Error in %s: %s", test_name, what);
        test_errors++;
        error_count++;
    endfunction

    // Mid-cycle compare, both sides only move on the rising edge
    a_group_matches: assert property (
        @(negedge clock) disable iff (!check_en)
        result == expected_q
    ) else report_mismatch("result", 64'(expected_q), 64'(result));

    a_flush_empties: assert property (
        @(negedge clock) disable iff (!check_en)
        flush_q |-> result_valids == '0
    ) else report_problem("a result slot is valid right after reset or squash");

    function automatic rename_packet_pkg::dispatch_slot_t make_slot(
        rename_pkg::arch_reg_t src1,
        rename_pkg::arch_reg_t src2,
        logic                  dest_valid,
        rename_pkg::arch_reg_t dest,
        rename_pkg::rob_tag_t  tag
    );
        rename_packet_pkg::dispatch_slot_t s;
        s.valid      = 1'b1;
        s.src1       = src1;
        s.src2       = src2;
        s.dest_valid = dest_valid;
        s.dest       = dest;
        s.dest_tag   = tag;
        return s;
    endfunction

    function automatic rename_packet_pkg::cdb_bcast_t make_bcast(rename_pkg::rob_tag_t tag);
        rename_packet_pkg::cdb_bcast_t b;
        b.valid = 1'b1;
        b.tag   = tag;
        return b;
    endfunction

    // Inputs change on the falling edge only
    task automatic present(dispatch_group_t d, cdb_group_t c, logic sq);
        @(negedge clock);
        dispatch = d;
        cdb      = c;
        squash   = sq;
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // Idle cycle lets the last group get checked before the verdict
    task automatic end_test();
        present('0, '0, 1'b0);
        @(posedge clock);
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("%s: %s, %0d errors", test_name,
                 (test_errors == 0) ? "passed" : "failed", test_errors);
    endtask

    task automatic test_reset_and_squash();
        dispatch_group_t d;
        begin_test("reset_and_squash");
        d    = '0;
        d[0] = make_slot(5'd3, 5'd4, 1'b1, 5'd3, 5'd7);
        d[1] = make_slot(5'd3, 5'd0, 1'b1, 5'd4, 5'd8);
        present(d, '0, 1'b0);
        d    = '0;
        d[0] = make_slot(5'd3, 5'd4, 1'b0, 5'd1, 5'd0);      // Sees x3 and x4 mapped
        present(d, '0, 1'b0);
        d    = '0;
        d[2] = make_slot(5'd9, 5'd3, 1'b1, 5'd9, 5'd11);     // Lost to the squash
        present(d, '0, 1'b1);
        d    = '0;
        d[0] = make_slot(5'd3, 5'd4, 1'b0, 5'd1, 5'd0);
        d[1] = make_slot(5'd9, 5'd0, 1'b0, 5'd1, 5'd0);      // Everything unmapped again
        present(d, '0, 1'b0);
        end_test();
    endtask

    task automatic test_mapped_not_ready();
        dispatch_group_t d;
        begin_test("mapped_not_ready");
        d    = '0;
        d[1] = make_slot(5'd1, 5'd2, 1'b1, 5'd5, 5'd12);
        present(d, '0, 1'b0);
        present('0, '0, 1'b0);
        d    = '0;
        d[0] = make_slot(5'd2, 5'd5, 1'b0, 5'd1, 5'd0);
        d[2] = make_slot(5'd5, 5'd6, 1'b0, 5'd1, 5'd0);
        present(d, '0, 1'b0);
        end_test();
    endtask

    task automatic test_wakeup_and_bypass();
        dispatch_group_t d;
        cdb_group_t      c;
        begin_test("wakeup_and_bypass");
        d    = '0;
        d[0] = make_slot(5'd1, 5'd2, 1'b1, 5'd6, 5'd20);
        present(d, '0, 1'b0);
        d    = '0;
        c    = '0;
        d[0] = make_slot(5'd6, 5'd0, 1'b0, 5'd1, 5'd0);      // Ready through the bypass
        d[1] = make_slot(5'd2, 5'd3, 1'b1, 5'd7, 5'd9);
        c[2] = make_bcast(5'd20);
        present(d, c, 1'b0);
        d    = '0;
        c    = '0;
        d[0] = make_slot(5'd6, 5'd7, 1'b0, 5'd1, 5'd0);      // x6 ready from the table
        d[1] = make_slot(5'd0, 5'd1, 1'b1, 5'd7, 5'd10);     // Write beats wake-up of 9
        d[2] = make_slot(5'd7, 5'd6, 1'b0, 5'd1, 5'd0);
        c[0] = make_bcast(5'd9);
        present(d, c, 1'b0);
        d    = '0;
        d[0] = make_slot(5'd7, 5'd6, 1'b0, 5'd1, 5'd0);
        present(d, '0, 1'b0);
        end_test();
    endtask

    task automatic test_group_forwarding();
        dispatch_group_t d;
        cdb_group_t      c;
        begin_test("group_forwarding");
        d    = '0;
        d[0] = make_slot(5'd1, 5'd2, 1'b1, 5'd8, 5'd30);
        present(d, '0, 1'b0);
        d    = '0;
        c    = '0;
        d[0] = make_slot(5'd8, 5'd0, 1'b1, 5'd8, 5'd1);      // Table entry, bypass ready
        d[1] = make_slot(5'd8, 5'd0, 1'b1, 5'd8, 5'd2);      // Takes tag 1 from slot 0
        d[2] = make_slot(5'd0, 5'd8, 1'b0, 5'd1, 5'd0);      // Takes tag 2 from slot 1
        c[1] = make_bcast(5'd30);
        present(d, c, 1'b0);
        d    = '0;
        d[1] = make_slot(5'd8, 5'd0, 1'b0, 5'd1, 5'd0);      // Highest slot won the write
        present(d, '0, 1'b0);
        end_test();
    endtask

    task automatic test_random_traffic();
        dispatch_group_t       d;
        cdb_group_t            c;
        logic                  sq;
        logic                  wr;
        rename_pkg::arch_reg_t src1;
        rename_pkg::arch_reg_t src2;
        rename_pkg::arch_reg_t dest;
        rename_pkg::rob_tag_t  tag;
        int unsigned           base;
        int unsigned           step;
        begin_test("random_traffic");
        for (int n = 0; n < random_cycles; n++) begin
            d = '0;
            c = '0;
            for (int i = 0; i < rename_pkg::issue_width; i++) begin
                src1 = rename_pkg::arch_reg_t'(lcg_range(8));        // Few regs, many hits
                src2 = rename_pkg::arch_reg_t'(lcg_range(8));
                wr   = (lcg_range(2) == 1);
                dest = rename_pkg::arch_reg_t'(1 + lcg_range(7));    // Never x0
                tag  = rename_pkg::rob_tag_t'(lcg_range(32));
                if (lcg_range(4) != 0) begin
                    d[i] = make_slot(src1, src2, wr, dest, tag);
                end
            end
            base = lcg_range(32);
            step = 1 + lcg_range(10);                               // Keeps tags distinct
            for (int p = 0; p < cdb_ports; p++) begin
                if (lcg_range(2) == 1) begin
                    c[p] = make_bcast(rename_pkg::rob_tag_t'((base + p * step) % 32));
                end
            end
            sq = (lcg_range(32) == 0);
            present(d, c, sq);
        end
        end_test();
    endtask

    initial begin
        reset    = 1'b1;
        squash   = 1'b0;
        dispatch = '0;
        cdb      = '0;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
        test_reset_and_squash();
        test_mapped_not_ready();
        test_wakeup_and_bypass();
        test_group_forwarding();
        test_random_traffic();
        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Stops a run that outlives every test budget
    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 watchdog_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
rename_pkg.sv
rename_packet_pkg.sv
map_table_store.sv
source_lookup.sv
rename_top.sv
tb_rename.sv

//--- run.sh
#!/bin/sh
# Build and run the rename map table testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_rename \
    -f project.f \
    -o tb_rename_sim

./obj_dir/tb_rename_sim | tee sim.log

if grep -q "TEST OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
